// File: vid_pkg.sv
// video line path definitions
`default_nettype none

package vid_pkg;

	// display modes as coded in vconf[1:0]
	localparam logic [1:0] M_ZX = 2'd0;	// zx screen, code 3 maps here too
	localparam logic [1:0] M_HC = 2'd1;	// 16 colours
	localparam logic [1:0] M_XC = 2'd2;	// 256 colours

	// render modes shared by decoder and renderer
	localparam logic [1:0] R_ZX = 2'd0;
	localparam logic [1:0] R_HC = 2'd1;
	localparam logic [1:0] R_XC = 2'd2;

	// dram bandwidth, total slots
	localparam logic [1:0] BW2 = 2'b00;	// 1 of 2
	localparam logic [1:0] BW4 = 2'b01;	// 1 of 4
	localparam logic [1:0] BW8 = 2'b11;	// 1 of 8

	// slots actually needed
	localparam logic [2:0] BU1 = 3'b001;

	// raster size in pixel clocks and lines
	localparam logic [8:0] H_TOTAL = 9'd448;
	localparam logic [8:0] V_TOTAL = 9'd320;

	localparam int WORD_W = 16;	// dram word

endpackage

`default_nettype wire

// File: vid_raster.sv
// raster timer
`timescale 1ns/1ns
`default_nettype none

module vid_raster (
	input wire clk,
	input wire rst_n,
	output logic [8:0] hcnt,
	output logic [8:0] vcnt,
	output logic line_start
);

	logic h_last;	// last column of the line
	logic v_last;

	assign h_last = (hcnt == vid_pkg::H_TOTAL - 9'd1);
	assign v_last = (vcnt == vid_pkg::V_TOTAL - 9'd1);

	// free running column and line counters
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
			line_start <= 1'b0;
		end
		else
		begin
			line_start <= h_last;	// high while hcnt is 0
			if (h_last)
			begin
				hcnt <= '0;
				vcnt <= v_last ? 9'd0 : vcnt + 9'd1;	// new line, or new frame
			end
			else
				hcnt <= hcnt + 9'd1;
		end
	end

	// counters must never pass the raster size
	hcnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		hcnt < vid_pkg::H_TOTAL && vcnt < vid_pkg::V_TOTAL);

endmodule

`default_nettype wire

// File: video_mode.sv
// video mode decoder
`timescale 1ns/1ns
`default_nettype none

module video_mode (
	input wire clk,
	input wire rst_n,
	input wire [7:0] vconf,
	input wire [7:0] vpage,
	input wire zvpage_wr,
	input wire [8:0] hcnt,
	input wire [8:0] vcnt,
	input wire line_start,
	output logic [7:0] vpage_d,
	output logic [1:0] render_mode,
	output logic nogfx,
	output logic [8:0] hpix_beg,
	output logic [8:0] hpix_end,
	output logic [8:0] vpix_beg,
	output logic [8:0] vpix_end,
	output logic fetch_stb,
	output logic [20:0] video_addr,
	output logic [4:0] video_bw
);

	logic [7:0] vconf_d;	// config of the current line
	logic [1:0] vmod;
	logic [1:0] rres;
	logic [4:0] go_offs;	// fetch lead in columns
	logic [2:0] fmask;	// fetch period minus one
	logic [8:0] width;
	logic [8:0] zx_sum;
	logic [7:0] n_words;	// words per line
	logic [8:0] f_beg;
	logic v_act;
	logic fetch_on;
	logic [2:0] fcnt;
	logic [7:0] cnt_col;
	logic [8:0] cnt_row;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;

	// config latched once per line, page also on cpu write
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vconf_d <= '0;
			vpage_d <= '0;
		end
		else
		begin
			if (line_start)
				vconf_d <= vconf;
			if (line_start || zvpage_wr)
				vpage_d <= vpage;
		end
	end

	assign vmod = (vconf_d[1:0] == 2'd3) ? vid_pkg::M_ZX : vconf_d[1:0];
	assign rres = vconf_d[7:6];
	assign nogfx = vconf_d[5];

	// display window per resolution
	always_comb
	begin
		case (rres)
			2'd0:
			begin
				hpix_beg = 9'd140;	// 256 wide
				hpix_end = 9'd396;
				vpix_beg = 9'd80;	// 192 rows
				vpix_end = 9'd272;
			end
			2'd1:
			begin
				hpix_beg = 9'd108;	// 320 x 200
				hpix_end = 9'd428;
				vpix_beg = 9'd76;
				vpix_end = 9'd276;
			end
			2'd2:
			begin
				hpix_beg = 9'd108;	// 320 x 240
				hpix_end = 9'd428;
				vpix_beg = 9'd56;
				vpix_end = 9'd296;
			end
			default:
			begin
				hpix_beg = 9'd88;	// 360 x 288, no border
				hpix_end = 9'd448;
				vpix_beg = 9'd32;
				vpix_end = 9'd320;
			end
		endcase
	end

	assign width = hpix_end - hpix_beg;
	assign zx_sum = width + 9'd15;	// round up to whole 16 pixel cells
	assign cnt_row = vcnt - vpix_beg;
	assign v_act = (vcnt >= vpix_beg) && (vcnt < vpix_end);

	// zx address, gfx and attributes alternate
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};

	// per mode pacing, bandwidth and address
	always_comb
	begin
		case (vmod)
			vid_pkg::M_HC:
			begin
				render_mode = vid_pkg::R_HC;
				go_offs = 5'd6;
				fmask = 3'd3;	// every 4th clock
				n_words = {1'b0, width[8:2]};
				video_bw = {vid_pkg::BW4, vid_pkg::BU1};
				video_addr = {vpage_d[7:3], cnt_row, cnt_col[6:0]};
			end
			vid_pkg::M_XC:
			begin
				render_mode = vid_pkg::R_XC;
				go_offs = 5'd4;
				fmask = 3'd1;	// every other clock
				n_words = width[8:1];
				video_bw = {vid_pkg::BW2, vid_pkg::BU1};
				video_addr = {vpage_d[7:4], cnt_row, cnt_col[7:0]};
			end
			default:
			begin
				render_mode = vid_pkg::R_ZX;
				go_offs = 5'd18;
				fmask = 3'd7;
				n_words = {2'b00, zx_sum[8:4], 1'b0};	// gfx + attr per cell
				video_bw = {vid_pkg::BW8, vid_pkg::BU1};
				video_addr = {vpage_d, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
			end
		endcase
	end

	assign f_beg = hpix_beg - {4'd0, go_offs};

	// fetch pacing, one word per period until the line is covered
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_on <= 1'b0;
			fcnt <= '0;
			cnt_col <= '0;
		end
		else if (!fetch_on)
		begin
			fcnt <= '0;
			cnt_col <= '0;
			fetch_on <= (hcnt == f_beg) && v_act && !nogfx;
		end
		else
		begin
			fcnt <= fcnt + 3'd1;
			if (fetch_stb)
			begin
				cnt_col <= cnt_col + 8'd1;
				if (cnt_col == n_words - 8'd1)	// last word issued
					fetch_on <= 1'b0;
			end
		end
	end

	assign fetch_stb = fetch_on && ((fcnt & fmask) == 3'd0);

	// fetching only ever happens on active gfx lines
	fetch_in_window: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_stb |-> v_act && !nogfx);

endmodule

`default_nettype wire

// File: vid_fifo.sv
// video word fifo
`timescale 1ns/1ns
`default_nettype none

module vid_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input wire clk,
	input wire rst_n,
	input wire wr,
	input wire [WIDTH-1:0] wdata,
	input wire rd,
	output logic [WIDTH-1:0] rdata,
	output logic empty,
	output logic full,
	output logic fifo_err
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0] wp;	// msb is the wrap bit
	logic [AW:0] rp;
	logic push;
	logic pop;

	assign empty = (wp == rp);
	assign full = (wp[AW] != rp[AW]) && (wp[AW-1:0] == rp[AW-1:0]);
	assign push = wr && !full;
	assign pop = rd && !empty;
	assign rdata = mem[rp[AW-1:0]];	// head word, fall through

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wp[AW-1:0]] <= wdata;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wp <= '0;
			rp <= '0;
			fifo_err <= 1'b0;
		end
		else
		begin
			if (push)
				wp <= wp + 1'b1;
			if (pop)
				rp <= rp + 1'b1;
			if (wr && full)
				fifo_err <= 1'b1;	// dropped word, sticky
		end
	end

	// renderer must only pull available words
	no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);
	// dram has no back pressure so depth must cover latency
	no_push_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);

endmodule

`default_nettype wire

// File: vid_render.sv
// pixel renderer
`timescale 1ns/1ns
`default_nettype none

module vid_render (
	input wire clk,
	input wire rst_n,
	input wire [8:0] hcnt,
	input wire [8:0] vcnt,
	input wire [8:0] hpix_beg,
	input wire [8:0] hpix_end,
	input wire [8:0] vpix_beg,
	input wire [8:0] vpix_end,
	input wire [1:0] render_mode,
	input wire nogfx,
	input wire [7:0] border,
	input wire [vid_pkg::WORD_W-1:0] rdata,
	input wire empty,
	output logic rd,
	output logic [7:0] pix,
	output logic pix_de,
	output logic underrun
);

	logic armed;	// line expects words
	logic waiting;
	logic emit;
	logic start;
	logic [3:0] wcnt;	// latency margin
	logic [1:0] mode;
	logic zx;
	logic [8:0] pcnt;	// pixel in line
	logic [8:0] wend;
	logic reload;
	logic prepop;	// zx gfx word ahead of its cell
	logic src_ok;
	logic [vid_pkg::WORD_W-1:0] wreg;
	logic [vid_pkg::WORD_W-1:0] areg;
	logic [vid_pkg::WORD_W-1:0] gnxt;
	logic [vid_pkg::WORD_W-1:0] wsrc;
	logic [vid_pkg::WORD_W-1:0] asrc;
	logic wval;
	logic gnv;
	logic bit_g;
	logic [7:0] abyte;
	logic [7:0] colour;
	logic [7:0] pix_q;

	assign start = armed && !waiting && !emit && !empty;	// first word of the line
	assign zx = (mode != vid_pkg::R_HC) && (mode != vid_pkg::R_XC);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			armed <= 1'b0;
			waiting <= 1'b0;
			emit <= 1'b0;
			wcnt <= '0;
			pcnt <= '0;
			pix_de <= 1'b0;
			underrun <= 1'b0;
		end
		else
		begin
			if (hcnt == 9'd1)	// decoder config settled
				armed <= !nogfx && vcnt >= vpix_beg && vcnt < vpix_end;
			else if (start)
				armed <= 1'b0;
			if (start)
			begin
				waiting <= 1'b1;
				wcnt <= (render_mode == vid_pkg::R_ZX) ? 4'd11 : 4'd3;	// zx needs 2 words
			end
			else if (waiting)
			begin
				wcnt <= wcnt - 4'd1;
				if (wcnt == 4'd0)
				begin
					waiting <= 1'b0;
					emit <= 1'b1;
					pcnt <= '0;
				end
			end
			else if (emit)
			begin
				pcnt <= pcnt + 9'd1;
				if (pcnt == wend)
					emit <= 1'b0;
			end
			pix_de <= emit;
			if ((reload || prepop) && empty)
				underrun <= 1'b1;	// word was late
		end
	end

	// line shape frozen when the first word shows up
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			mode <= render_mode;
			wend <= hpix_end - hpix_beg - 9'd1;
		end
	end

	always_comb
	begin
		case (mode)
			vid_pkg::R_XC: reload = emit && pcnt[0] == 1'b0;
			vid_pkg::R_HC: reload = emit && pcnt[1:0] == 2'd0;
			default: reload = emit && pcnt[3:0] == 4'd0;	// attr word
		endcase
	end

	assign prepop = zx && ((waiting && wcnt == 4'd0) ||
		(emit && pcnt[3:0] == 4'hf && pcnt != wend));
	assign rd = (reload || prepop) && !empty;

	// word sources, fresh word on reload
	assign wsrc = reload ? (zx ? gnxt : rdata) : wreg;
	assign asrc = reload ? rdata : areg;
	assign src_ok = reload ? (!empty && (gnv || !zx)) : wval;

	always_ff @(posedge clk)
	begin
		if (prepop)
		begin
			gnxt <= rdata;
			gnv <= !empty;
		end
		if (reload)
		begin
			wreg <= wsrc;
			areg <= rdata;
			wval <= src_ok;
		end
	end

	assign bit_g = wsrc[4'd15 - pcnt[3:0]];	// msb first
	assign abyte = pcnt[3] ? asrc[7:0] : asrc[15:8];	// attr byte per gfx half

	always_comb
	begin
		case (mode)
			vid_pkg::R_XC: colour = pcnt[0] ? wsrc[7:0] : wsrc[15:8];
			vid_pkg::R_HC: colour = {4'd0, wsrc[4'd15 - {pcnt[1:0], 2'b00} -: 4]};
			default: colour = {4'd0, abyte[6], bit_g ? abyte[2:0] : abyte[5:3]};	// ink or paper
		endcase
	end

	always_ff @(posedge clk)
	begin
		pix_q <= src_ok ? colour : border;
	end

	assign pix = pix_de ? pix_q : border;

endmodule

`default_nettype wire

// File: vid_core.sv
// graphics line path top
`timescale 1ns/1ns
`default_nettype none

module vid_core #(
	parameter int FIFO_DEPTH = 8
) (
	input wire clk,
	input wire rst_n,
	input wire [7:0] vconf,
	input wire [7:0] vpage,
	input wire zvpage_wr,
	input wire [7:0] border,
	input wire [vid_pkg::WORD_W-1:0] dram_data,
	input wire dram_stb,
	output logic fetch_stb,
	output logic [20:0] video_addr,
	output logic [4:0] video_bw,
	output logic [7:0] pix,
	output logic pix_de,
	output logic underrun,
	output logic fifo_err
);

	logic [8:0] hcnt;
	logic [8:0] vcnt;
	logic line_start;
	logic [1:0] render_mode;
	logic nogfx;
	logic [8:0] hpix_beg;
	logic [8:0] hpix_end;
	logic [8:0] vpix_beg;
	logic [8:0] vpix_end;
	logic [vid_pkg::WORD_W-1:0] rdata;
	logic empty;
	logic rd;

	vid_raster raster_inst (
		.clk(clk),
		.rst_n(rst_n),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.line_start(line_start)
	);

	video_mode mode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.vconf(vconf),
		.vpage(vpage),
		.zvpage_wr(zvpage_wr),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.line_start(line_start),
		.vpage_d(),	// page only feeds the address here
		.render_mode(render_mode),
		.nogfx(nogfx),
		.hpix_beg(hpix_beg),
		.hpix_end(hpix_end),
		.vpix_beg(vpix_beg),
		.vpix_end(vpix_end),
		.fetch_stb(fetch_stb),
		.video_addr(video_addr),
		.video_bw(video_bw)
	);

	vid_fifo #(
		.DEPTH(FIFO_DEPTH),
		.WIDTH(vid_pkg::WORD_W)
	) fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wr(dram_stb),
		.wdata(dram_data),
		.rd(rd),
		.rdata(rdata),
		.empty(empty),
		.full(),	// no back pressure to dram
		.fifo_err(fifo_err)
	);

	vid_render render_inst (
		.clk(clk),
		.rst_n(rst_n),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.hpix_beg(hpix_beg),
		.hpix_end(hpix_end),
		.vpix_beg(vpix_beg),
		.vpix_end(vpix_end),
		.render_mode(render_mode),
		.nogfx(nogfx),
		.border(border),
		.rdata(rdata),
		.empty(empty),
		.rd(rd),
		.pix(pix),
		.pix_de(pix_de),
		.underrun(underrun)
	);

endmodule

`default_nettype wire

// File: tb_vid_core.sv
// video line path testbench
`timescale 1ns/1ns
`default_nettype none

module tb_vid_core;

	localparam int H_TOT = 448;
	localparam int FRAME = 448 * 320;	// cycles per frame
	localparam int RUNS = 16;	// frame level runs over all tests
	localparam int LIMIT = RUNS * 4 * FRAME + 20000;

	logic clk;
	logic rst_n;
	logic [7:0] vconf;
	logic [7:0] vpage;
	logic zvpage_wr;
	logic [7:0] border;
	logic [15:0] dram_data = 16'h0000;
	logic dram_stb = 1'b0;
	logic fetch_stb;
	logic [20:0] video_addr;
	logic [4:0] video_bw;
	logic [7:0] pix;
	logic pix_de;
	logic underrun;
	logic fifo_err;

	int cyc = 0;
	int th = 0;	// mirror of the raster column
	int tv = 0;
	int errors = 0;
	int last_due = 0;
	int rq_due[$];	// dram replies in flight
	logic [15:0] rq_data[$];
	logic [20:0] fa[$];	// fetched addresses of a line
	logic [4:0] fb[$];
	logic [7:0] px[$];	// pixels while pix_de
	logic [15:0] wq[$];

	vid_core #(.FIFO_DEPTH(8)) vid_core_inst (
		.clk(clk), .rst_n(rst_n), .vconf(vconf), .vpage(vpage),
		.zvpage_wr(zvpage_wr), .border(border), .dram_data(dram_data),
		.dram_stb(dram_stb), .fetch_stb(fetch_stb), .video_addr(video_addr),
		.video_bw(video_bw), .pix(pix), .pix_de(pix_de), .underrun(underrun),
		.fifo_err(fifo_err)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// raster mirror and run limit
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (!rst_n)
		begin
			th <= 0;
			tv <= 0;
		end
		else if (th == H_TOT - 1)
		begin
			th <= 0;
			tv <= (tv == 319) ? 0 : tv + 1;
		end
		else
			th <= th + 1;
		if (cyc > LIMIT)
		begin
			$display("run took too long, timeout at cycle %0d", cyc);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// dram model, in order replies after 1 to 6 cycles
	always @(negedge clk)
	begin
		int due;
		dram_stb <= 1'b0;
		if (rq_due.size() > 0 && rq_due[0] == cyc)
		begin
			dram_stb <= 1'b1;
			dram_data <= rq_data.pop_front();
			void'(rq_due.pop_front());
		end
		if (fetch_stb)
		begin
			due = cyc + 1 + int'($urandom % 6);
			if (due <= last_due)
				due = last_due + 1;	// keep request order
			last_due = due;
			rq_due.push_back(due);
			rq_data.push_back(video_addr[15:0] ^ 16'h5a3c);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	function automatic int width_of(input int res);
		case (res)
			0: return 256;
			1, 2: return 320;
			default: return 360;
		endcase
	endfunction

	function automatic int words_of(input int mode, input int w);
		if (mode == 2)
			return w / 2;
		if (mode == 1)
			return w / 4;
		return ((w + 15) / 16) * 2;	// gfx and attr per cell
	endfunction

	function automatic logic [20:0] addr_of(input int mode, input logic [7:0] pg, input int k);
		logic [8:0] row;
		logic [7:0] col;
		row = 9'd0;	// first active line
		col = k[7:0];
		if (mode == 2)
			return {pg[7:4], row, col};
		if (mode == 1)
			return {pg[7:3], row, col[6:0]};
		if (col[0])
			return {pg, 1'b0, 3'b110, row[7:3], col[4:1]};
		return {pg, 1'b0, row[7:6], row[2:0], row[5:3], col[4:1]};
	endfunction

	function automatic logic [7:0] pix_of(input int mode, input int i);
		logic [15:0] g;
		logic [15:0] a;
		logic [7:0] ab;
		if (mode == 2)
		begin
			g = wq[i / 2];
			return (i % 2) ? g[7:0] : g[15:8];
		end
		if (mode == 1)
		begin
			g = wq[i / 4];
			return {4'd0, g[15 - 4 * (i % 4) -: 4]};
		end
		g = wq[(i / 16) * 2];
		a = wq[(i / 16) * 2 + 1];
		ab = (i % 16 < 8) ? a[15:8] : a[7:0];
		return {4'd0, ab[6], g[15 - i % 16] ? ab[2:0] : ab[5:3]};	// ink or paper
	endfunction

	task automatic wait_frame();
		do @(negedge clk); while (!(th == 0 && tv == 0));
	endtask

	// next line with fetches: addresses, bw codes and its pixel run
	// act 1 rewrites vconf, act 2 writes the page, after the 4th fetch
	task automatic capture_line(input int act, input logic [7:0] val);
		int n;
		int st;
		bit got;
		n = 0;
		st = 0;
		got = 0;
		fa.delete();
		fb.delete();
		px.delete();
		while (th != 0)
			@(negedge clk);
		forever
		begin
			if (fetch_stb)
			begin
				fa.push_back(video_addr);
				fb.push_back(video_bw);
				got = 1;
				if (fa.size() == 4 && act == 1)
					vconf = val;
				if (fa.size() == 4 && act == 2)
				begin
					vpage = val;
					zvpage_wr = 1'b1;
				end
			end
			case (st)
				0: if (!pix_de) st = 1;	// skip a run spilling in
				1: if (pix_de)
				begin
					st = 2;
					px.push_back(pix);
				end
				2: if (pix_de) px.push_back(pix); else st = 3;
				default: ;
			endcase
			if (got && st == 3)
				break;
			n++;
			if (n > 2 * FRAME)
			begin
				$display("no active line with pixels found");
				errors++;
				break;
			end
			@(negedge clk);
			zvpage_wr = 1'b0;
		end
	endtask

	// whole line against the address, bandwidth and pixel rules
	task automatic verify_line(input string name, input int mode, input int res,
		input logic [7:0] pg0, input logic [7:0] pg1);
		int w;
		logic [4:0] bw;
		w = width_of(res);
		bw = (mode == 2) ? 5'b00001 : (mode == 1) ? 5'b01001 : 5'b11001;
		check_val({name, " words"}, words_of(mode, w), fa.size());
		wq.delete();
		foreach (fa[k])
		begin
			check_val({name, " addr"}, addr_of(mode, (k >= 4) ? pg1 : pg0, k), fa[k]);
			check_val({name, " bw"}, bw, fb[k]);
			wq.push_back(fa[k][15:0] ^ 16'h5a3c);
		end
		check_val({name, " length"}, w, px.size());
		if (wq.size() >= words_of(mode, w))
			foreach (px[i])
				check_val({name, " pix"}, pix_of(mode, i), px[i]);
		check_val({name, " underrun"}, 0, underrun);
		check_val({name, " fifo_err"}, 0, fifo_err);
	endtask

	task automatic report(input string name, input int err0);
		$display("%s: %s", name, (errors == err0) ? "ok" : "errors");
	endtask

	task automatic test_reset();
		int e;
		e = errors;
		repeat (24)
		begin
			@(negedge clk);
			check_val("reset fetch_stb", 0, fetch_stb);
			check_val("reset pix_de", 0, pix_de);
			check_val("reset flags", 0, {underrun, fifo_err});
			check_val("reset pix", border, pix);
		end
		report("reset", e);
	endtask

	task automatic test_mode(input string name, input int mode, input int res);
		int e;
		e = errors;
		vconf = {res[1:0], 4'd0, mode[1:0]};
		wait_frame();
		capture_line(0, 8'h00);
		verify_line(name, mode, res, vpage, vpage);
		report(name, e);
	endtask

	task automatic test_midline_conf();
		int e;
		e = errors;
		vconf = 8'h02;	// 256c, switched to 16c mid line
		wait_frame();
		capture_line(1, 8'h01);
		verify_line("midline_conf", 2, 0, vpage, vpage);
		capture_line(0, 8'h00);
		check_val("midline_conf next bw", 5'b01001, fb.size() ? fb[0] : 5'b0);
		check_val("midline_conf next words", 64, fa.size());
		report("midline_conf", e);
	endtask

	task automatic test_nogfx();
		int e;
		e = errors;
		vconf = 8'h22;
		wait_frame();
		repeat (FRAME)
		begin
			@(negedge clk);
			check_val("nogfx fetch_stb", 0, fetch_stb);
			check_val("nogfx pix_de", 0, pix_de);
			check_val("nogfx pix", border, pix);
		end
		report("nogfx", e);
	endtask

	task automatic test_page_write();
		int e;
		e = errors;
		vconf = 8'h02;
		vpage = 8'h30;
		wait_frame();
		capture_line(2, 8'h90);	// new page from the 5th word
		verify_line("page_write", 2, 0, 8'h30, 8'h90);
		report("page_write", e);
	endtask

	initial
	begin
		void'($urandom(32'h0c2d_8a7f));
		rst_n = 1'b0;
		vconf = 8'h00;
		vpage = 8'h00;
		zvpage_wr = 1'b0;
		border = 8'h5b;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		test_reset();
		vpage = 8'h48;
		test_mode("addr_zx", 0, 0);
		test_mode("addr_16c", 1, 0);
		test_mode("addr_256c", 2, 0);
		for (int r = 1; r < 4; r++)
			for (int m = 0; m < 3; m++)
				test_mode($sformatf("pixels_m%0d_r%0d", m, r), m, r);
		test_midline_conf();
		test_nogfx();
		test_page_write();
		$display("done after %0d cycles, %0d errors", cyc, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: vid_core.f
vid_pkg.sv
vid_raster.sv
video_mode.sv
vid_fifo.sv
vid_render.sv
vid_core.sv
tb_vid_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video line path simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_vid_core -f vid_core.f -o sim_vid_core
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_vid_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	exit 1
fi
exit 0
